/* all.f */
common/dvb_pls_pkg.sv
hw/dvb_pls_dec/dvb_pls_symb_metric.sv
hw/dvb_pls_dec/dvb_pls_ctrl.sv
hw/dvb_pls_dec/dvb_pls_rm_dec.sv
hw/dvb_pls_dec/dvb_pls_dec.sv
tests/tb_dvb_pls_dec_assert.sv
tests/tb_dvb_pls_dec.sv

/* Bender.yml */
package:
  name: dvb_pls_dec

sources:
  # design, in compile order
  - common/dvb_pls_pkg.sv
  - hw/dvb_pls_dec/dvb_pls_symb_metric.sv
  - hw/dvb_pls_dec/dvb_pls_ctrl.sv
  - hw/dvb_pls_dec/dvb_pls_rm_dec.sv
  - hw/dvb_pls_dec/dvb_pls_dec.sv

  # testbench and bound checks
  - target: test
    files:
      - tests/tb_dvb_pls_dec_assert.sv
      - tests/tb_dvb_pls_dec.sv

/* tests/tb_dvb_pls_dec.sv */
/*
  directed testbench of the PLS header decoder
  frames are built by a local encoder model, amplitude 20, 6-bit samples
  one LFSR supplies codes, noise, input gaps and clock enable gaps
*/

`timescale 1ns/1ps

module tb_dvb_pls_dec;

  import dvb_pls_pkg::*;

  localparam int DAT_W      = 6;
  localparam int TAG_W      = 4;
  localparam int AMP        = 20;
  // worst frame with enable gaps stays well below this
  localparam int FRAME_CYC  = 400;
  // 128 clean + 4 x 8 + reset test
  localparam int FRAMES_ALL = 128 + 4 * 8 + 2;
  localparam int CYC_LIMIT  = FRAMES_ALL * FRAME_CYC + 1000;
  localparam int ENA_N      = 1024;

  logic                    iclk;
  logic                    ireset;
  logic                    iclkena = 1'b1;
  pls_strb_t               istrb;
  logic signed [DAT_W-1:0] idat_re;
  logic signed [DAT_W-1:0] idat_im;
  logic [TAG_W-1:0]        itag;
  logic                    ordy;
  logic                    oval;
  pls_code_t               odat;
  logic [TAG_W-1:0]        otag;

  // encoded frame, one (re, im) per symbol
  int          sym_re [PLS_SYMB_N];
  int          sym_im [PLS_SYMB_N];

  logic [31:0] lfsr_state = 32'h669a_f507;
  logic        ena_pat [ENA_N];
  logic        ena_gaps;
  int          cyc = 0;

  // decoded results as seen on enabled oval cycles
  pls_code_t        res_code [$];
  logic [TAG_W-1:0] res_tag [$];

  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;

  dvb_pls_dec #(
    .pDAT_W (DAT_W),
    .pTAG_W (TAG_W)
  ) DUT (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .istrb   (istrb),
    .idat_re (idat_re),
    .idat_im (idat_im),
    .itag    (itag),
    .ordy    (ordy),
    .oval    (oval),
    .odat    (odat),
    .otag    (otag)
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  //--------------------------------------------------------------------
  // cycle counter, enable pattern and watchdog
  //--------------------------------------------------------------------

  always @(posedge iclk) begin
    cyc     <= cyc + 1;
    iclkena <= ena_gaps ? ena_pat[cyc % ENA_N] : 1'b1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cyc);
      $display("TB FAILED");
      $finish;
    end
  end

  // output capture, the consumer takes odat only on an enabled cycle
  always @(posedge iclk) begin
    if (!ireset && oval && iclkena) begin
      res_code.push_back(odat);
      res_tag.push_back(otag);
    end
  end

  //--------------------------------------------------------------------
  // random source and encoder model
  //--------------------------------------------------------------------

  // galois form, right shift, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  // noise in -3..3, sign bit only taken for nonzero values
  function automatic int rand_noise();
    int mag;
    mag = rand_bits(2);
    if (mag == 0) begin
      return 0;
    end
    return rand_bit() ? -mag : mag;
  endfunction

  // y_i = b0 ^ (b1..b5 . i), symbols 2i and 2i+1, then scramble and map
  function automatic void encode_frame(input pls_code_t code);
    logic y;
    logic bv;
    int   a;
    for (int i = 0; i < PLS_PAIR_N; i++) begin
      y = code[6] ^ (^(code[5:1] & i[4:0]));
      for (int h = 0; h < 2; h++) begin
        bv = y ^ ((h == 1) ? code[0] : 1'b0) ^ PLS_SCRAMBLE[2*i+h];
        a  = bv ? -AMP : AMP;
        // pi/2 rotation on odd symbols
        sym_re[2*i+h] = (h == 0) ? a : -a;
        sym_im[2*i+h] = a;
      end
    end
  endfunction

  //--------------------------------------------------------------------
  // driver, result wait and checks
  //--------------------------------------------------------------------

  // sends the first nsym symbols, each held until the DUT takes it
  task automatic send_frame(input pls_code_t code, input logic [TAG_W-1:0] tag,
                            input bit gaps, input bit noisy, input int nsym);
    int n_re;
    int n_im;
    encode_frame(code);
    @(posedge iclk);
    for (int k = 0; k < nsym; k++) begin
      if (gaps && rand_bits(2) == 3) begin
        istrb <= '0;
        @(posedge iclk);
      end
      n_re = noisy ? rand_noise() : 0;
      n_im = noisy ? rand_noise() : 0;
      istrb   <= {k == 0, 1'b1, k == PLS_SYMB_N - 1};
      idat_re <= DAT_W'(sym_re[k] + n_re);
      idat_im <= DAT_W'(sym_im[k] + n_im);
      itag    <= tag;
      do @(posedge iclk); while (!(ordy && iclkena));
    end
    istrb <= '0;
  endtask

  task automatic check(input string name, input logic [31:0] exp,
                       input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // polls away from the active edge
  task automatic wait_result(input string name, input pls_code_t exp_code,
                             input logic [TAG_W-1:0] exp_tag, output pls_code_t got);
    int n;
    n   = 0;
    got = '0;
    while (res_code.size() == 0 && n < FRAME_CYC) begin
      @(negedge iclk);
      n++;
    end
    if (res_code.size() == 0) begin
      errors++;
      $display("%s: no output pulse within %0d cycles", name, FRAME_CYC);
    end else begin
      got = res_code.pop_front();
      check({name, " odat"}, exp_code, got);
      check({name, " otag"}, exp_tag, res_tag.pop_front());
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  //--------------------------------------------------------------------
  // tests
  //--------------------------------------------------------------------

  task automatic test_clean();
    int        e0;
    pls_code_t got;
    e0 = errors;
    for (int c = 0; c < 128; c++) begin
      send_frame(pls_code_t'(c), TAG_W'(c) ^ 4'ha, 0, 0, PLS_SYMB_N);
      wait_result("clean", pls_code_t'(c), TAG_W'(c) ^ 4'ha, got);
    end
    finish_test("clean", e0);
  endtask

  task automatic test_noisy();
    int        e0;
    pls_code_t code;
    pls_code_t got;
    e0 = errors;
    for (int f = 0; f < 8; f++) begin
      code = pls_code_t'(rand_bits(7));
      send_frame(code, TAG_W'(f), 0, 1, PLS_SYMB_N);
      wait_result("noisy", code, TAG_W'(f), got);
    end
    finish_test("noisy", e0);
  endtask

  // next frame is offered while ordy is still low
  task automatic test_back_to_back();
    int               e0;
    pls_code_t        codes [8];
    logic [TAG_W-1:0] tags [8];
    pls_code_t        got;
    e0 = errors;
    for (int f = 0; f < 8; f++) begin
      codes[f] = pls_code_t'(rand_bits(7));
      tags[f]  = TAG_W'(15 - f);
      send_frame(codes[f], tags[f], 0, 0, PLS_SYMB_N);
    end
    for (int f = 0; f < 8; f++) begin
      wait_result("back_to_back", codes[f], tags[f], got);
    end
    finish_test("back_to_back", e0);
  endtask

  task automatic test_input_gaps();
    int        e0;
    pls_code_t code;
    pls_code_t got;
    e0 = errors;
    for (int f = 0; f < 8; f++) begin
      code = pls_code_t'(rand_bits(7));
      send_frame(code, TAG_W'(f + 3), 1, 0, PLS_SYMB_N);
      wait_result("input_gaps", code, TAG_W'(f + 3), got);
    end
    finish_test("input_gaps", e0);
  endtask

  // about one cycle in four disabled
  task automatic test_clkena_gaps();
    int        e0;
    pls_code_t code;
    pls_code_t got;
    e0 = errors;
    for (int i = 0; i < ENA_N; i++) begin
      ena_pat[i] = (rand_bits(2) != 3);
    end
    @(posedge iclk);
    ena_gaps <= 1'b1;
    for (int f = 0; f < 8; f++) begin
      code = pls_code_t'(rand_bits(7));
      send_frame(code, TAG_W'(f + 8), 0, 0, PLS_SYMB_N);
      wait_result("clkena_gaps", code, TAG_W'(f + 8), got);
    end
    @(posedge iclk);
    ena_gaps <= 1'b0;
    repeat (2) @(posedge iclk);
    // one result per frame, nothing extra
    check("clkena_gaps extra outputs", 0, res_code.size());
    finish_test("clkena_gaps", e0);
  endtask

  task automatic test_reset_mid_frame();
    int        e0;
    int        seen;
    pls_code_t code;
    pls_code_t got;
    e0   = errors;
    seen = 0;
    code = pls_code_t'(rand_bits(7));
    send_frame(code, 4'h5, 0, 0, PLS_SYMB_N / 2);
    @(posedge iclk);
    ireset <= 1'b1;
    repeat (4) @(posedge iclk);
    ireset <= 1'b0;
    @(negedge iclk);
    check("reset oval", 0, oval);
    check("reset ordy", 1, ordy);
    // the aborted frame must never produce a result
    repeat (FRAME_CYC / 2) begin
      @(negedge iclk);
      seen += int'(oval);
    end
    check("reset stray oval", 0, seen);
    check("reset stray result", 0, res_code.size());
    send_frame(code, 4'h9, 0, 0, PLS_SYMB_N);
    wait_result("reset_mid_frame", code, 4'h9, got);
    finish_test("reset_mid_frame", e0);
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------

  initial begin
    ireset   = 1'b1;
    istrb    = '0;
    idat_re  = '0;
    idat_im  = '0;
    itag     = '0;
    ena_gaps = 1'b0;
    repeat (4) @(posedge iclk);
    ireset <= 1'b0;

    test_clean();
    test_noisy();
    test_back_to_back();
    test_input_gaps();
    test_clkena_gaps();
    test_reset_mid_frame();

    // bound protocol checks count into the result too
    if (DUT.u_checks.fail_cnt != 0) begin
      $display("%0d protocol assertion failures", DUT.u_checks.fail_cnt);
      errors += DUT.u_checks.fail_cnt;
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tests/tb_dvb_pls_dec_assert.sv */
/*
  stream protocol checks bound into the PLS decoder top level
  all properties count enabled clock cycles only
  fail_cnt is read by the testbench at the end of the run
*/

`timescale 1ns/1ps

module pls_stream_checks (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  dvb_pls_pkg::pls_strb_t istrb,
  input  logic                   ordy,
  input  logic                   oval
);

  import dvb_pls_pkg::*;

  int         fail_cnt = 0;
  logic       acc;
  // accepted symbols since sop, sop itself counts as one
  logic [6:0] acc_cnt;

  assign acc = iclkena & istrb.val & ordy;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      acc_cnt <= '0;
    end else if (acc) begin
      acc_cnt <= istrb.sop ? 7'd1 : acc_cnt + 1'b1;
    end
  end

  // output is a single enabled-cycle pulse
  a_oval_single: assert property (@(posedge iclk) disable iff (ireset)
    (oval && iclkena) |=> !oval)
    else begin
      fail_cnt++;
      $error("oval held for a second enabled cycle");
    end

  // back-pressure: once stopped, ordy only rises after the output pulse,
  // so no symbol of the next frame is taken while the decode runs
  a_no_accept: assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && !ordy && !oval) |=> !ordy)
    else begin
      fail_cnt++;
      $error("ordy rose before the output pulse");
    end

  a_ordy_after_oval: assert property (@(posedge iclk) disable iff (ireset)
    (oval && iclkena) |=> ordy)
    else begin
      fail_cnt++;
      $error("ordy still low after the output pulse");
    end

  // eop is symbol 63 of its frame
  a_frame_len: assert property (@(posedge iclk) disable iff (ireset)
    (acc && istrb.eop) |-> (acc_cnt == 7'd63 && !istrb.sop))
    else begin
      fail_cnt++;
      $error("eop not 63 accepted symbols after sop");
    end

endmodule

bind dvb_pls_dec pls_stream_checks u_checks (
  .iclk    (iclk),
  .ireset  (ireset),
  .iclkena (iclkena),
  .istrb   (istrb),
  .ordy    (ordy),
  .oval    (oval)
);

/* hw/dvb_pls_dec/dvb_pls_dec.sv */
/*
  DVB-S2 PLS header decoder, 64 soft symbols in, 7-bit pls code out
  inputs should avoid the most negative sample code, the demapper
  and descrambler have no headroom for it
  oval is a single pulse without back-pressure
*/

`timescale 1ns/1ps

module dvb_pls_dec #(
  parameter int pDAT_W = 6,
  parameter int pTAG_W = 4
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  dvb_pls_pkg::pls_strb_t   istrb,
  input  logic signed [pDAT_W-1:0] idat_re,
  input  logic signed [pDAT_W-1:0] idat_im,
  input  logic [pTAG_W-1:0]        itag,
  output logic                     ordy,
  output logic                     oval,
  output dvb_pls_pkg::pls_code_t   odat,
  output logic [pTAG_W-1:0]        otag
);

  import dvb_pls_pkg::*;

  // strobes qualified by ordy
  pls_strb_t               strb_acc;

  // demapper
  pls_strb_t               dem_strb;
  logic signed [pDAT_W:0]  dem_dat;
  logic                    odd_r;
  logic                    cur_odd;

  // tag of the frame being loaded and of the frame being decoded
  logic [pTAG_W-1:0]       tag_in;
  logic [pTAG_W-1:0]       tag_frame;

  // metric stage
  logic                    sm_val;
  logic                    sm_last;
  pair_idx_t               sm_idx;
  logic signed [pDAT_W+1:0] sm_add;
  logic signed [pDAT_W+1:0] sm_sub;

  // control and rm decoder
  logic                    fht_start;
  logic                    fht_done;
  logic                    sort_start;
  logic                    sort_done;
  pls_code_t               rm_dat;

  //--------------------------------------------------------------------
  // input qualification and demapper
  //--------------------------------------------------------------------

  always_comb begin
    strb_acc.val = istrb.val & ordy;
    strb_acc.sop = istrb.sop & strb_acc.val;
    strb_acc.eop = istrb.eop & strb_acc.val;
  end

  // sop always starts an even symbol
  assign cur_odd = istrb.sop ? 1'b0 : odd_r;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      odd_r    <= 1'b0;
      dem_strb <= '0;
    end else if (iclkena) begin
      dem_strb <= strb_acc;
      if (strb_acc.val) begin
        odd_r <= ~cur_odd;
      end
    end
  end

  // undo pi/2 rotation: even symbols on re+im, odd symbols on im-re
  always_ff @(posedge iclk) begin
    if (iclkena && strb_acc.val) begin
      dem_dat <= cur_odd ? (idat_im - idat_re) : (idat_re + idat_im);
    end
  end

  //--------------------------------------------------------------------
  // descrambler and pair metrics
  //--------------------------------------------------------------------

  dvb_pls_symb_metric #(
    .pDAT_W (pDAT_W)
  ) u_symb_metric (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .istrb   (dem_strb),
    .idat    (dem_dat),
    .oval    (sm_val),
    .olast   (sm_last),
    .oidx    (sm_idx),
    .oadd    (sm_add),
    .osub    (sm_sub)
  );

  //--------------------------------------------------------------------
  // sequencing
  //--------------------------------------------------------------------

  dvb_pls_ctrl u_ctrl (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .istrb      (strb_acc),
    .fht_done   (fht_done),
    .sort_done  (sort_done),
    .ordy       (ordy),
    .fht_start  (fht_start),
    .sort_start (sort_start)
  );

  //--------------------------------------------------------------------
  // reed-muller decoder
  //--------------------------------------------------------------------

  dvb_pls_rm_dec #(
    .pDAT_W (pDAT_W)
  ) u_rm_dec (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .ival       (sm_val),
    .iidx       (sm_idx),
    .iadd       (sm_add),
    .isub       (sm_sub),
    .fht_start  (fht_start),
    .sort_start (sort_start),
    .fht_done   (fht_done),
    .oval       (sort_done),
    .odat       (rm_dat)
  );

  //--------------------------------------------------------------------
  // tag path and output register
  //--------------------------------------------------------------------

  // tag follows the frame: taken at sop, handed over with the last pair
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (strb_acc.sop) begin
        tag_in <= itag;
      end
      if (sm_last) begin
        tag_frame <= tag_in;
      end
      if (sort_done) begin
        odat <= rm_dat;
        otag <= tag_frame;
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= sort_done;
    end
  end

endmodule

/* hw/dvb_pls_dec/dvb_pls_rm_dec.sv */
/*
  first order reed-muller decoder by fast hadamard transform
  two 32-entry buffers: pair sums (b6 = 0) and differences (b6 = 1)
  load, transform and search must not overlap, the control unit ensures it
*/

`timescale 1ns/1ps

module dvb_pls_rm_dec #(
  parameter int pDAT_W = 6
) (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      ival,
  input  dvb_pls_pkg::pair_idx_t    iidx,
  input  logic signed [pDAT_W+1:0]  iadd,
  input  logic signed [pDAT_W+1:0]  isub,
  input  logic                      fht_start,
  input  logic                      sort_start,
  output logic                      fht_done,
  output logic                      oval,
  output dvb_pls_pkg::pls_code_t    odat
);

  import dvb_pls_pkg::*;

  // five butterfly stages, one bit of growth each
  localparam int MW = pDAT_W + 7;

  typedef logic signed [MW-1:0] fht_t;
  typedef logic [MW-1:0]        mag_t;

  fht_t      mem [2][PLS_PAIR_N];

  // transform counters
  logic      fht_run;
  logic [2:0] stage;
  logic [3:0] bfly;
  pair_idx_t lo_mask;
  pair_idx_t idx_a;
  pair_idx_t idx_b;
  fht_t      bf_sum [2];
  fht_t      bf_dif [2];

  // search
  logic      sort_run;
  logic      sort_fin;
  pair_idx_t sort_cnt;
  mag_t      cand_mag [2];
  mag_t      best_mag [2];
  pair_idx_t best_idx [2];
  logic      best_neg [2];
  logic      pick1;

  //--------------------------------------------------------------------
  // butterfly addressing and datapath
  //--------------------------------------------------------------------

  always_comb begin
    // span of the current stage is 1 << stage
    lo_mask = (pair_idx_t'(1) << stage) - pair_idx_t'(1);
    // open a zero at bit position stage for the upper leg
    idx_a   = ((pair_idx_t'(bfly) & ~lo_mask) << 1) | (pair_idx_t'(bfly) & lo_mask);
    idx_b   = idx_a | (pair_idx_t'(1) << stage);
    for (int b = 0; b < 2; b++) begin
      bf_sum[b]   = mem[b][idx_a] + mem[b][idx_b];
      bf_dif[b]   = mem[b][idx_a] - mem[b][idx_b];
      cand_mag[b] = mem[b][sort_cnt][MW-1] ? mag_t'(-mem[b][sort_cnt])
                                           : mag_t'(mem[b][sort_cnt]);
    end
  end

  // buffer 1 wins only on a strictly larger magnitude
  assign pick1 = (best_mag[1] > best_mag[0]);

  //--------------------------------------------------------------------
  // phase control
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      fht_run  <= 1'b0;
      stage    <= '0;
      bfly     <= '0;
      fht_done <= 1'b0;
      sort_run <= 1'b0;
      sort_cnt <= '0;
      sort_fin <= 1'b0;
      oval     <= 1'b0;
    end else if (iclkena) begin
      fht_done <= 1'b0;
      sort_fin <= 1'b0;
      // result register fills in the sort_fin cycle
      oval     <= sort_fin;
      if (fht_start) begin
        fht_run <= 1'b1;
        stage   <= '0;
        bfly    <= '0;
      end else if (fht_run) begin
        bfly <= bfly + 1'b1;
        if (bfly == 4'd15) begin
          stage <= stage + 1'b1;
          if (stage == 3'd4) begin
            fht_run  <= 1'b0;
            fht_done <= 1'b1;
          end
        end
      end
      if (sort_start) begin
        sort_run <= 1'b1;
        sort_cnt <= '0;
      end else if (sort_run) begin
        sort_cnt <= sort_cnt + 1'b1;
        if (sort_cnt == 5'd31) begin
          sort_run <= 1'b0;
          sort_fin <= 1'b1;
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // buffers, in-place transform and maximum search
  //--------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ival) begin
        mem[0][iidx] <= fht_t'(iadd);
        mem[1][iidx] <= fht_t'(isub);
      end
      // both buffers step through the same butterfly
      if (fht_run) begin
        for (int b = 0; b < 2; b++) begin
          mem[b][idx_a] <= bf_sum[b];
          mem[b][idx_b] <= bf_dif[b];
        end
      end
      // first entry seeds the search, later ones must be strictly larger
      if (sort_run) begin
        for (int b = 0; b < 2; b++) begin
          if (sort_cnt == '0 || cand_mag[b] > best_mag[b]) begin
            best_mag[b] <= cand_mag[b];
            best_idx[b] <= sort_cnt;
            best_neg[b] <= mem[b][sort_cnt][MW-1];
          end
        end
      end
      // sign gives b0, index gives b1..b5, buffer gives b6
      if (sort_fin) begin
        odat <= pick1 ? {best_neg[1], best_idx[1], 1'b1}
                      : {best_neg[0], best_idx[0], 1'b0};
      end
    end
  end

endmodule

/* hw/dvb_pls_dec/dvb_pls_ctrl.sv */
/*
  frame sequencing of the PLS decoder
  istrb must already be qualified by ordy
  ordy is low from the cycle after eop until the result is out
*/

`timescale 1ns/1ps

module dvb_pls_ctrl (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  dvb_pls_pkg::pls_strb_t istrb,
  input  logic                   fht_done,
  input  logic                   sort_done,
  output logic                   ordy,
  output logic                   fht_start,
  output logic                   sort_start
);

  import dvb_pls_pkg::*;

  ctrl_state_t state;

  // waits out the demapper, metric and buffer write stages
  logic [1:0]  flush_cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state      <= IDLE;
      ordy       <= 1'b1;
      fht_start  <= 1'b0;
      sort_start <= 1'b0;
      flush_cnt  <= '0;
    end else if (iclkena) begin
      // start outputs are single pulses
      fht_start  <= 1'b0;
      sort_start <= 1'b0;
      case (state)
        IDLE: begin
          if (istrb.sop) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          // stop the source right after the last symbol
          if (istrb.eop) begin
            state     <= FHT;
            ordy      <= 1'b0;
            flush_cnt <= 2'd2;
          end
        end
        FHT: begin
          if (flush_cnt != 2'd0) begin
            flush_cnt <= flush_cnt - 1'b1;
            // last pair is in the buffers once the count runs out
            fht_start <= (flush_cnt == 2'd1);
          end
          if (fht_done) begin
            state      <= SORT;
            sort_start <= 1'b1;
          end
        end
        SORT: begin
          if (sort_done) begin
            state <= DONE;
          end
        end
        DONE: begin
          // output register fires now, source may resume next cycle
          ordy  <= 1'b1;
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

/* hw/dvb_pls_dec/dvb_pls_symb_metric.sv */
/*
  descrambler and symbol pair folding
  expects exactly 64 symbols from sop, odd symbol closes a pair
  one cycle from input strobe to pair output
*/

`timescale 1ns/1ps

module dvb_pls_symb_metric #(
  parameter int pDAT_W = 6
) (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  dvb_pls_pkg::pls_strb_t    istrb,
  input  logic signed [pDAT_W:0]    idat,
  output logic                      oval,
  output logic                      olast,
  output dvb_pls_pkg::pair_idx_t    oidx,
  output logic signed [pDAT_W+1:0]  oadd,
  output logic signed [pDAT_W+1:0]  osub
);

  import dvb_pls_pkg::*;

  typedef logic signed [pDAT_W+1:0] metr_t;

  symb_idx_t symb_cnt;
  symb_idx_t cur_idx;
  metr_t     dsc;
  metr_t     even_hold;

  // symbol position, sop forces zero
  assign cur_idx = istrb.sop ? '0 : symb_cnt;

  // scramble bit set means flip the sign
  assign dsc = PLS_SCRAMBLE[cur_idx] ? -metr_t'(idat) : metr_t'(idat);

  //--------------------------------------------------------------------
  // counter and strobes
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      symb_cnt <= '0;
      oval     <= 1'b0;
      olast    <= 1'b0;
    end else if (iclkena) begin
      // a pair is complete on each odd symbol
      oval  <= istrb.val & cur_idx[0];
      // eop is symbol 63, the odd half of pair 31
      olast <= istrb.val & istrb.eop;
      if (istrb.val) begin
        symb_cnt <= cur_idx + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------
  // pair folding
  //--------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && istrb.val) begin
      if (!cur_idx[0]) begin
        even_hold <= dsc;
      end else begin
        oidx <= cur_idx[5:1];
        // sum carries b6 = 0, difference carries b6 = 1
        oadd <= even_hold + dsc;
        osub <= even_hold - dsc;
      end
    end
  end

endmodule

/* common/dvb_pls_pkg.sv */
/*
  shared constants and types of the PLS header decoder
  a frame is exactly 64 pi/2-BPSK symbols, one pls code per frame
  scramble bit k belongs to symbol k, symbol 0 first on the air
*/

package dvb_pls_pkg;

  //--------------------------------------------------------------------
  // frame geometry
  //--------------------------------------------------------------------

  localparam int PLS_SYMB_N = 64;
  // one hadamard point per symbol pair
  localparam int PLS_PAIR_N = 32;
  localparam int PLS_CODE_W = 7;

  // standard PLS scrambling sequence, bit-reversed so that bit k is symbol k
  localparam logic [PLS_SYMB_N-1:0] PLS_SCRAMBLE = 64'hFE34_42CA_93C1_B98E;

  //--------------------------------------------------------------------
  // vector types
  //--------------------------------------------------------------------

  // {b0, b1..b5, b6}: constant term, linear terms, pair repetition bit
  typedef logic [PLS_CODE_W-1:0] pls_code_t;

  typedef logic [4:0] pair_idx_t;
  typedef logic [5:0] symb_idx_t;

  // framing strobes of the symbol stream
  typedef struct packed {
    logic sop;
    logic val;
    logic eop;
  } pls_strb_t;

  // control FSM
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    FHT,
    SORT,
    DONE
  } ctrl_state_t;

endpackage
